// ==== bbox/bbox_bank_store.sv ====
// Two-bank per-label box store; the read bank always holds the last complete frame
`default_nettype none

module bbox_bank_store (
	input  logic                  clk,
	input  logic                  rst,
	input  frame_pkg::lab_pixel_t lab_i,
	output bbox_pkg::bbox_t       boxes_o [frame_pkg::num_labels],  // Read bank boxes
	output logic [frame_pkg::num_labels-1:0] active_o               // Read bank flags
);

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------
	bbox_pkg::bbox_t boxes_q  [bbox_pkg::num_banks][frame_pkg::num_labels];
	logic [frame_pkg::num_labels-1:0] active_q [bbox_pkg::num_banks];

	bbox_pkg::bank_t wr_bank_q;   // Bank collecting the current frame
	bbox_pkg::bank_t rd_bank;     // Bank shown to the highlighter

	assign rd_bank = wr_bank_q + bbox_pkg::bank_t'(1);

	// ------------------------------------------------------------
	// Box growth
	// ------------------------------------------------------------
	bbox_pkg::bbox_t cur_box;
	bbox_pkg::bbox_t next_box;
	logic            grow;

	assign grow    = lab_i.valid && lab_i.motion;
	assign cur_box = boxes_q[wr_bank_q][lab_i.label];

	always_comb begin
		if (!active_q[wr_bank_q][lab_i.label]) begin
			// First pixel of this label, box is a single point
			next_box.min_x = lab_i.x;
			next_box.max_x = lab_i.x;
			next_box.min_y = lab_i.y;
			next_box.max_y = lab_i.y;
		end else begin
			next_box = cur_box;
			if (lab_i.x < cur_box.min_x) next_box.min_x = lab_i.x;
			if (lab_i.x > cur_box.max_x) next_box.max_x = lab_i.x;
			if (lab_i.y < cur_box.min_y) next_box.min_y = lab_i.y;
			if (lab_i.y > cur_box.max_y) next_box.max_y = lab_i.y;
		end
	end

	always_ff @(posedge clk) begin
		if (grow)
			boxes_q[wr_bank_q][lab_i.label] <= next_box;
	end

	// ------------------------------------------------------------
	// Active flags and bank swap
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int b = 0; b < bbox_pkg::num_banks; b++)
				active_q[b] <= '0;
			wr_bank_q <= '0;
		end else if (lab_i.valid) begin
			if (lab_i.motion)
				active_q[wr_bank_q][lab_i.label] <= 1'b1;  // Last pixel lands before the swap
			if (lab_i.last) begin
				wr_bank_q         <= rd_bank;
				active_q[rd_bank] <= '0;   // Old read bank starts the next frame empty
			end
		end
	end

	// Read side
	always_comb begin
		for (int i = 0; i < frame_pkg::num_labels; i++)
			boxes_o[i] = boxes_q[rd_bank][i];
	end

	assign active_o = active_q[rd_bank];

endmodule

`default_nettype wire

// ==== common/bbox_pkg.sv ====
// Bounding-box record and bank types; two banks only, so one frame of box history
`default_nettype none

package bbox_pkg;

	// ------------------------------------------------------------
	// Box record
	// ------------------------------------------------------------

	// Inclusive corner coordinates, 42 bits
	// Only meaningful while the matching active flag is set
	typedef struct packed {
		frame_pkg::xcoord_t min_x;
		frame_pkg::xcoord_t max_x;
		frame_pkg::ycoord_t min_y;
		frame_pkg::ycoord_t max_y;
	} bbox_t;

	// ------------------------------------------------------------
	// Banking
	// ------------------------------------------------------------

	// One bank collects the current frame, the other is read out
	localparam int num_banks = 2;
	localparam int bank_bits = $clog2(num_banks);

	typedef logic [bank_bits-1:0] bank_t;  // Bank index

	// ------------------------------------------------------------
	// Overlay
	// ------------------------------------------------------------

	// Colour drawn on every box edge
	localparam frame_pkg::pixel_t highlight_color = 32'hFF000000;

endpackage

`default_nettype wire

// ==== common/frame_pkg.sv ====
// Raster geometry and labelled-pixel types; lines up to 2048 pixels, 1024 rows, 15 labels
`default_nettype none

package frame_pkg;

	// ------------------------------------------------------------
	// Geometry
	// ------------------------------------------------------------
	localparam int x_bits    = 11;            // Column coordinate width
	localparam int y_bits    = 10;            // Row coordinate width
	localparam int max_width = 1 << x_bits;   // Line buffer depth, 2048

	// ------------------------------------------------------------
	// Labels
	// ------------------------------------------------------------
	localparam int label_bits = 4;
	localparam int num_labels = 1 << label_bits;  // Label 0 is background, 15 is the top

	typedef logic [31:0]           pixel_t;   // Colour word, passed through untouched
	typedef logic [x_bits-1:0]     xcoord_t;
	typedef logic [y_bits-1:0]     ycoord_t;
	typedef logic [label_bits-1:0] label_t;

	// Labelled pixel as it leaves the labeler
	// Label is 0 whenever motion is low
	typedef struct packed {
		logic    valid;   // Enabled cycle
		logic    motion;  // Pixel is part of a blob
		label_t  label;   // Component label
		xcoord_t x;       // Column of this pixel
		ycoord_t y;       // Row of this pixel
		pixel_t  rgb;     // Input colour word
		logic    last;    // Final pixel of the frame
	} lab_pixel_t;

endpackage

`default_nettype wire

// ==== hdl/bbox_overlay_top.sv ====
// Motion-box overlay; boxes drawn in frame N come from frame N-1, no back-pressure
`default_nettype none

module bbox_overlay_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable_i,     // One pixel per high cycle
	input  logic               motion_i,
	input  logic               last_i,       // Marks the frame's last pixel
	input  frame_pkg::pixel_t  rgb_i,
	input  frame_pkg::xcoord_t width_i,      // Pixels per line
	output frame_pkg::pixel_t  pixel_o,
	output logic               pixel_valid_o
);

	frame_pkg::lab_pixel_t            lab;       // Labelled pixel for store and overlay
	bbox_pkg::bbox_t                  boxes [frame_pkg::num_labels];
	logic [frame_pkg::num_labels-1:0] active;

	// ------------------------------------------------------------
	// Labels each pixel
	// ------------------------------------------------------------
	raster_labeler u_labeler (
		.clk      (clk),
		.rst      (rst),
		.enable_i (enable_i),
		.motion_i (motion_i),
		.last_i   (last_i),
		.rgb_i    (rgb_i),
		.width_i  (width_i),
		.lab_o    (lab)
	);

	// Box store that swaps banks at frame end
	bbox_bank_store u_store (
		.clk      (clk),
		.rst      (rst),
		.lab_i    (lab),
		.boxes_o  (boxes),
		.active_o (active)
	);

	// Draws the outlines
	edge_highlighter u_highlight (
		.clk           (clk),
		.rst           (rst),
		.lab_i         (lab),
		.boxes_i       (boxes),
		.active_i      (active),
		.pixel_o       (pixel_o),
		.pixel_valid_o (pixel_valid_o)
	);

endmodule

`default_nettype wire

// ==== hdl/edge_highlighter.sv ====
// Outlines last frame's boxes on the stream; label 0 never draws, one cycle of latency
`default_nettype none

module edge_highlighter (
	input  logic                  clk,
	input  logic                  rst,
	input  frame_pkg::lab_pixel_t lab_i,
	input  bbox_pkg::bbox_t       boxes_i [frame_pkg::num_labels],
	input  logic [frame_pkg::num_labels-1:0] active_i,
	output frame_pkg::pixel_t     pixel_o,
	output logic                  pixel_valid_o
);

	// ------------------------------------------------------------
	// Edge test
	// ------------------------------------------------------------
	logic on_edge;
	logic on_vert;     // Left or right side with the row inside the box
	logic on_horiz;    // Top or bottom side with the column inside the box

	always_comb begin
		on_edge = 1'b0;
		for (int i = 1; i < frame_pkg::num_labels; i++) begin
			on_vert = (lab_i.x == boxes_i[i].min_x || lab_i.x == boxes_i[i].max_x)
				&& (boxes_i[i].min_y <= lab_i.y) && (lab_i.y <= boxes_i[i].max_y);
			on_horiz = (lab_i.y == boxes_i[i].min_y || lab_i.y == boxes_i[i].max_y)
				&& (boxes_i[i].min_x <= lab_i.x) && (lab_i.x <= boxes_i[i].max_x);
			if (active_i[i] && (on_vert || on_horiz))
				on_edge = 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pixel_o       <= '0;
			pixel_valid_o <= 1'b0;
		end else begin
			pixel_valid_o <= lab_i.valid;   // Drops for a stalled cycle
			if (lab_i.valid)
				pixel_o <= on_edge ? bbox_pkg::highlight_color : lab_i.rgb;
		end
	end

endmodule

`default_nettype wire

// ==== labeler/raster_labeler.sv ====
// Left-then-top labeler, no merging; a U shape keeps two labels, labels stop at 15
`default_nettype none

module raster_labeler (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enable_i,   // Pixel strobe
	input  logic                  motion_i,   // Motion flag of this pixel
	input  logic                  last_i,     // Final pixel of the frame
	input  frame_pkg::pixel_t     rgb_i,
	input  frame_pkg::xcoord_t    width_i,    // Line length, at least 1
	output frame_pkg::lab_pixel_t lab_o
);

	// ------------------------------------------------------------
	// Raster position
	// ------------------------------------------------------------
	frame_pkg::xcoord_t x_q;
	frame_pkg::ycoord_t y_q;
	logic               line_end;

	assign line_end = (x_q == width_i - frame_pkg::xcoord_t'(1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x_q <= '0;
			y_q <= '0;
		end else if (enable_i) begin
			if (last_i) begin          // Next frame starts at the origin
				x_q <= '0;
				y_q <= '0;
			end else if (line_end) begin
				x_q <= '0;
				y_q <= y_q + frame_pkg::ycoord_t'(1);
			end else begin
				x_q <= x_q + frame_pkg::xcoord_t'(1);
			end
		end
	end

	// ------------------------------------------------------------
	// Label line buffer
	// ------------------------------------------------------------
	// Entries left of x already hold this row, the rest the row above
	frame_pkg::label_t line_q [frame_pkg::max_width];
	frame_pkg::label_t left_label;
	frame_pkg::label_t top_label;
	frame_pkg::label_t next_label_q;    // Fresh label counter
	frame_pkg::label_t pix_label;       // Label given to this pixel
	logic              take_fresh;

	assign left_label = (x_q == '0) ? '0 : line_q[x_q - frame_pkg::xcoord_t'(1)];
	assign top_label  = line_q[x_q];

	always_comb begin
		take_fresh = 1'b0;
		if (!motion_i) begin
			pix_label = '0;                   // Background
		end else if (left_label != '0) begin
			pix_label = left_label;           // Join the left run
		end else if (top_label != '0) begin
			pix_label = top_label;            // Continue from above
		end else begin
			pix_label  = next_label_q;
			take_fresh = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < frame_pkg::max_width; i++)
				line_q[i] <= '0;
		end else if (enable_i) begin
			line_q[x_q] <= pix_label;
			if (last_i) begin                 // Next frame sees no row above
				for (int i = 0; i < frame_pkg::max_width; i++)
					line_q[i] <= '0;
			end
		end
	end

	// Fresh labels run 1 up to the top label and then stick there
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			next_label_q <= frame_pkg::label_t'(1);
		else if (enable_i) begin
			if (last_i)
				next_label_q <= frame_pkg::label_t'(1);
			else if (take_fresh
					&& next_label_q != frame_pkg::label_t'(frame_pkg::num_labels - 1))
				next_label_q <= next_label_q + frame_pkg::label_t'(1);
		end
	end

	// ------------------------------------------------------------
	// Labelled pixel out
	// ------------------------------------------------------------
	always_comb begin
		lab_o.valid  = enable_i;
		lab_o.motion = motion_i;
		lab_o.label  = pix_label;
		lab_o.x      = x_q;
		lab_o.y      = y_q;
		lab_o.rgb    = rgb_i;
		lab_o.last   = last_i;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+testbench
common/frame_pkg.sv
common/bbox_pkg.sv
labeler/raster_labeler.sv
bbox/bbox_bank_store.sv
hdl/edge_highlighter.sv
hdl/bbox_overlay_top.sv
testbench/tb_bbox_overlay.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the overlay testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing -Wno-fatal \
	-f project.f \
	--top-module tb_bbox_overlay \
	-Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$build_dir/sim_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

grep -q "SIMULATION PASSED" "$log"
if [ $? -ne 0 ]; then
	echo "Pass message not found in $log"
	exit 1
fi

exit 0

// ==== testbench/tb_tasks.svh ====
// Directed tests; each one leaves a background frame behind so the next starts without boxes
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	// ------------------------------------------------------------
	// Frame builders and small checks
	// ------------------------------------------------------------
	task automatic clear_motion();
		for (int y = 0; y < frame_h; y++)
			for (int x = 0; x < frame_w; x++)
				mot_map[y][x] = 1'b0;
	endtask

	task automatic add_rect(input int x0, input int y0, input int x1, input int y1);
		for (int y = y0; y <= y1; y++)
			for (int x = x0; x <= x1; x++)
				mot_map[y][x] = 1'b1;
	endtask

	// Pixels on the outline of a w by h box
	function automatic int outline_count(input int w, input int h);
		if (w == 1 || h == 1)
			return w * h;
		return 2 * w + 2 * h - 4;
	endfunction

	task automatic expect_outline(input string what, input int want);
		checks++;
		if (hl_count != want) begin
			errors++;
			$display("Wrong outline size in %s: %0d highlighted pixels, expected %0d",
				what, hl_count, want);
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests_run++;
		$display("Test %s done, %0d errors", name, errors - errs_at_start);
	endtask

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------
	task automatic after_reset_idle();
		int e;
		e = errors;
		repeat (4) begin           // Enable held low
			@(posedge clk);
			#1;
			checks += 2;
			if (pixel_valid_o !== 1'b0) begin
				errors++;
				$display("Mismatch pixel_valid_o after reset: got %h expected %h",
					pixel_valid_o, 1'b0);
			end
			if (pixel_o !== 32'h0) begin
				errors++;
				$display("Mismatch pixel_o after reset: got %h expected %h",
					pixel_o, 32'h0);
			end
			#4;
		end
		finish_test("reset", e);
	endtask

	task automatic pass_through_frames();
		int e;
		e = errors;
		clear_motion();
		add_rect(2, 1, 6, 4);
		run_frame(1'b0);           // Nothing drawn in the first frame
		expect_outline("first frame", 0);
		clear_motion();
		run_frame(1'b0);
		expect_outline("frame after blob", outline_count(5, 4));
		run_frame(1'b0);           // Follows a background frame
		expect_outline("frame after background", 0);
		finish_test("passthrough", e);
	endtask

	task automatic single_blob_outline();
		int e;
		e = errors;
		clear_motion();
		add_rect(3, 2, 10, 5);
		run_frame(1'b0);
		expect_outline("blob frame", 0);
		clear_motion();
		run_frame(1'b0);
		expect_outline("outline frame", outline_count(8, 4));
		finish_test("single_blob", e);
	endtask

	task automatic two_blob_outlines();
		int e;
		e = errors;
		clear_motion();
		add_rect(1, 1, 3, 3);
		add_rect(10, 4, 14, 6);
		run_frame(1'b0);
		clear_motion();
		run_frame(1'b0);
		expect_outline("two blobs", outline_count(3, 3) + outline_count(5, 3));
		// L shape, lower part reaches further left and gets its own label
		add_rect(8, 1, 11, 2);
		add_rect(4, 3, 11, 4);
		run_frame(1'b0);
		clear_motion();
		run_frame(1'b0);
		expect_outline("L shape", outline_count(4, 2) + outline_count(8, 2));
		finish_test("two_blobs", e);
	endtask

	task automatic stalled_frames();
		int e;
		e = errors;
		clear_motion();
		add_rect(5, 1, 12, 6);
		run_frame(1'b1);
		expect_outline("stalled blob frame", 0);
		clear_motion();
		run_frame(1'b1);
		expect_outline("stalled outline frame", outline_count(8, 6));
		finish_test("stall", e);
	endtask

	task automatic blob_replacement();
		int e;
		e = errors;
		clear_motion();
		add_rect(1, 1, 4, 2);
		run_frame(1'b0);
		clear_motion();
		add_rect(9, 3, 14, 6);
		run_frame(1'b0);           // Shows the first blob only
		expect_outline("first replacement frame", outline_count(4, 2));
		clear_motion();
		run_frame(1'b0);           // Shows the second blob only
		expect_outline("second replacement frame", outline_count(6, 4));
		finish_test("replacement", e);
	endtask

`endif

// ==== testbench/tb_bbox_overlay.sv ====
// Overlay testbench; frames fixed at 16 by 8, the model keeps one frame of boxes like the DUT
`default_nettype none

module tb_bbox_overlay;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 40;
	localparam int frame_w    = 16;
	localparam int frame_h    = 8;
	localparam int num_frames = 14;   // Frames over all tests
	localparam int max_gap    = 2;    // Longest stall before one pixel
	// Every frame at full length, stall frames at worst case, plus reset and margin
	localparam int watchdog_cycles = (num_frames + 2 * max_gap) * frame_w * frame_h + 200;
	localparam logic [31:0] highlight = 32'hFF000000;

	logic        clk;
	logic        rst;
	logic        enable_i;
	logic        motion_i;
	logic        last_i;
	logic [31:0] rgb_i;
	logic [10:0] width_i;
	logic [31:0] pixel_o;
	logic        pixel_valid_o;

	int errors;
	int checks;
	int tests_run;
	int hl_count;      // Highlighted outputs in the last frame

	// ------------------------------------------------------------
	// Reference model state
	// ------------------------------------------------------------
	typedef struct packed {
		logic act;
		int   x0;
		int   x1;
		int   y0;
		int   y1;
	} ref_box_t;

	logic     mot_map [frame_h][frame_w];   // Motion pattern of the next frame
	int       lab_map [frame_h][frame_w];   // Labels given in the current frame
	ref_box_t cur_box [16];                 // Frame being collected
	ref_box_t prev_box [16];                // Frame being drawn
	int       next_fresh;

	always #(clk_period / 2) clk = ~clk;

	bbox_overlay_top UUT (
		.clk           (clk),
		.rst           (rst),
		.enable_i      (enable_i),
		.motion_i      (motion_i),
		.last_i        (last_i),
		.rgb_i         (rgb_i),
		.width_i       (width_i),
		.pixel_o       (pixel_o),
		.pixel_valid_o (pixel_valid_o)
	);

	// Watchdog
	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: run did not end within %0d cycles", watchdog_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	// Drives one cycle at edge+5 and samples the response 1 ns after the next edge
	task automatic send_pixel(input logic en, input logic mot, input logic lst,
			input logic [31:0] word, input logic [31:0] exp_word, input int x, input int y);
		enable_i = en;
		motion_i = mot;
		last_i   = lst;
		rgb_i    = word;
		@(posedge clk);
		#1;
		checks++;
		if (pixel_valid_o !== en) begin
			errors++;
			$display("Mismatch pixel_valid_o at x=%0d y=%0d: got %h expected %h",
				x, y, pixel_valid_o, en);
		end
		if (en) begin
			checks++;
			if (pixel_o !== exp_word) begin
				errors++;
				$display("Mismatch pixel_o at x=%0d y=%0d: got %h expected %h",
					x, y, pixel_o, exp_word);
			end
			if (pixel_o === highlight)
				hl_count++;
		end
		#4;
		enable_i = 1'b0;   // Idle unless the next call drives again
	endtask

	// Edge rule against the boxes of the previous frame
	function automatic logic [31:0] predict_pixel(input int x, input int y,
			input logic [31:0] word);
		logic on_v;
		logic on_h;
		for (int l = 1; l < 16; l++) begin
			on_v = (x == prev_box[l].x0 || x == prev_box[l].x1)
				&& y >= prev_box[l].y0 && y <= prev_box[l].y1;
			on_h = (y == prev_box[l].y0 || y == prev_box[l].y1)
				&& x >= prev_box[l].x0 && x <= prev_box[l].x1;
			if (prev_box[l].act && (on_v || on_h))
				return highlight;
		end
		return word;
	endfunction

	// Left, then top, then a fresh label; box starts or widens
	task automatic label_and_grow(input int x, input int y);
		int left;
		int top;
		int lab;
		lab_map[y][x] = 0;
		if (!mot_map[y][x])
			return;
		left = (x > 0) ? lab_map[y][x-1] : 0;
		top  = (y > 0) ? lab_map[y-1][x] : 0;
		if (left != 0)
			lab = left;
		else if (top != 0)
			lab = top;
		else begin
			lab = next_fresh;
			if (next_fresh < 15)
				next_fresh++;   // Sticks at 15
		end
		lab_map[y][x] = lab;
		if (!cur_box[lab].act)
			cur_box[lab] = '{1'b1, x, x, y, y};
		else begin
			if (x < cur_box[lab].x0) cur_box[lab].x0 = x;
			if (x > cur_box[lab].x1) cur_box[lab].x1 = x;
			if (y < cur_box[lab].y0) cur_box[lab].y0 = y;
			if (y > cur_box[lab].y1) cur_box[lab].y1 = y;
		end
	endtask

	// Streams mot_map with random words and optional enable gaps
	task automatic run_frame(input bit stall);
		int          gaps;
		logic [31:0] word;
		logic [31:0] exp_word;
		logic        lst;
		hl_count   = 0;
		next_fresh = 1;
		for (int y = 0; y < frame_h; y++) begin
			for (int x = 0; x < frame_w; x++) begin
				gaps = 0;
				if (stall && ($urandom % 4 == 0))
					gaps = 1 + $urandom % max_gap;
				repeat (gaps) send_pixel(1'b0, 1'b0, 1'b0, 32'h0, 32'h0, x, y);
				word     = $urandom;
				exp_word = predict_pixel(x, y, word);
				label_and_grow(x, y);
				lst = (x == frame_w - 1) && (y == frame_h - 1);
				send_pixel(1'b1, mot_map[y][x], lst, word, exp_word, x, y);
			end
		end
		for (int l = 0; l < 16; l++) begin   // Bank swap
			prev_box[l]    = cur_box[l];
			cur_box[l].act = 1'b0;
		end
	endtask

	`include "tb_tasks.svh"

	initial begin
		void'($urandom(32'hb80b_3c24));
		clk       = 1'b0;
		rst       = 1'b1;
		enable_i  = 1'b0;
		motion_i  = 1'b0;
		last_i    = 1'b0;
		rgb_i     = '0;
		width_i   = 11'(frame_w);
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		hl_count  = 0;
		for (int l = 0; l < 16; l++) begin
			cur_box[l]  = '0;
			prev_box[l] = '0;
		end
		repeat (5) @(posedge clk);
		#5 rst = 1'b0;
		after_reset_idle();
		pass_through_frames();
		single_blob_outline();
		two_blob_outlines();
		stalled_frames();
		blob_replacement();
		$display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
